// ==== fc_irq_macros.svh ====
// Interrupt block constants
`ifndef FC_IRQ_MACROS_SVH
`define FC_IRQ_MACROS_SVH

//**************************************************
// Interrupt lines
//**************************************************

// Number of event / interrupt lines
`define FC_NB_LINES 32
// Width of a line id
`define FC_IRQ_ID_W 5

//**************************************************
// SoC event FIFO
//**************************************************

`define FC_EVT_ID_W 8
`define FC_EVT_FIFO_DEPTH 4
// Shared line that stays pending while the FIFO holds events
`define FC_SOC_EVT_LINE 26

`endif

// ==== fc_irq_pkg.sv ====
// Interrupt block types
`include "fc_irq_macros.svh"

package fc_irq_pkg;

    // Request presented to the core
    typedef struct packed {
        logic                    valid;
        logic [`FC_IRQ_ID_W-1:0] id;
    } irq_req_t;

    // Acknowledge from the core, also broadcast to the lines
    typedef struct packed {
        logic                    valid;
        logic [`FC_IRQ_ID_W-1:0] id;
    } irq_ack_t;

    // Popped SoC event
    typedef struct packed {
        logic                    valid;
        logic [`FC_EVT_ID_W-1:0] id;
    } soc_evt_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT_ACK
    } arb_state_e;

endpackage

// ==== fc_event_ingress.sv ====
// Event ingress and SoC event FIFO
`timescale 1ns/10ps
`include "fc_irq_macros.svh"

module fc_event_ingress import fc_irq_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [`FC_NB_LINES-1:0]  events_i,
    input  logic                     event_fifo_valid_i,
    input  logic [`FC_EVT_ID_W-1:0]  event_fifo_data_i,
    input  irq_ack_t                 ack_i,
    output logic                     event_fifo_fulln_o,
    output logic [`FC_NB_LINES-1:0]  set_vec_o,
    output soc_evt_t                 soc_evt_o
);

    localparam int PTR_W = $clog2(`FC_EVT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FC_EVT_FIFO_DEPTH + 1);

    logic [`FC_EVT_ID_W-1:0] fifo_mem [`FC_EVT_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [CNT_W-1:0]        fifo_cnt_q;
    logic                    fifo_push;
    logic                    fifo_pop;
    logic                    fifo_keep;
    logic                    soc_valid_q;
    logic [`FC_EVT_ID_W-1:0] soc_id_q;

    //**************************************************
    // FIFO control
    //**************************************************
    assign event_fifo_fulln_o = (fifo_cnt_q != CNT_W'(`FC_EVT_FIFO_DEPTH));
    assign fifo_push = event_fifo_valid_i & event_fifo_fulln_o;
    // Acknowledge of the shared line pops one entry, if there is one
    assign fifo_pop  = ack_i.valid & (ack_i.id == `FC_IRQ_ID_W'(`FC_SOC_EVT_LINE))
                     & (fifo_cnt_q != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            fifo_cnt_q  <= '0;
            soc_valid_q <= 1'b0;
        end else begin
            if (fifo_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (fifo_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            fifo_cnt_q  <= fifo_cnt_q + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
            soc_valid_q <= fifo_pop;
        end
    end

    // Storage and popped id
    always_ff @(posedge clk_i) begin
        if (fifo_push) fifo_mem[wr_ptr_q] <= event_fifo_data_i;
        if (fifo_pop)  soc_id_q <= fifo_mem[rd_ptr_q];
    end

    assign soc_evt_o = '{valid: soc_valid_q, id: soc_id_q};

    //**************************************************
    // Set vector
    //**************************************************
    // Shared line is set while an entry survives this cycle's pop
    assign fifo_keep = (fifo_cnt_q > CNT_W'(1)) | ((fifo_cnt_q == CNT_W'(1)) & ~fifo_pop);

    always_comb begin
        set_vec_o = events_i;
        set_vec_o[`FC_SOC_EVT_LINE] = events_i[`FC_SOC_EVT_LINE] | fifo_keep;
    end

    // Pointers must also show an entry whenever the FIFO is popped
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fifo_pop |-> (wr_ptr_q != rd_ptr_q) || (fifo_cnt_q == CNT_W'(`FC_EVT_FIFO_DEPTH)));

endmodule

// ==== fc_irq_line.sv ====
// Single interrupt line
`timescale 1ns/10ps
`include "fc_irq_macros.svh"

module fc_irq_line import fc_irq_pkg::*; #(
    parameter int unsigned LINE_ID = 0
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     set_i,
    input  logic     mask_i,
    input  irq_ack_t ack_i,
    output logic     req_o
);

    localparam logic [`FC_IRQ_ID_W-1:0] MY_ID = `FC_IRQ_ID_W'(LINE_ID);

    logic pending_q;
    logic clr;

    // Acknowledge addressed to this line
    assign clr = ack_i.valid & (ack_i.id == MY_ID);

    // Sticky pending flag, set wins over clear
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (set_i) begin
            pending_q <= 1'b1;
        end else if (clr) begin
            pending_q <= 1'b0;
        end
    end

    // Mask only gates the request, pending is kept
    assign req_o = pending_q & mask_i;

    // The arbiter only acknowledges lines it saw pending
    a_ack_when_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        clr |-> pending_q);

endmodule

// ==== fc_irq_arbiter.sv ====
// Interrupt arbiter towards the core
`timescale 1ns/10ps
`include "fc_irq_macros.svh"

module fc_irq_arbiter import fc_irq_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`FC_NB_LINES-1:0] line_req_i,
    input  irq_ack_t                core_ack_i,
    output irq_req_t                core_irq_o,
    output irq_ack_t                ack_bcast_o
);

    arb_state_e              state_q;
    logic                    irq_valid_q;
    logic [`FC_IRQ_ID_W-1:0] irq_id_q;
    logic                    any_req;
    logic [`FC_IRQ_ID_W-1:0] sel_id;
    logic                    ack_accept;

    //**************************************************
    // Highest line selection
    //**************************************************
    always_comb begin
        sel_id = '0;
        // Later hits overwrite earlier ones, so the top line wins
        for (int i = 0; i < `FC_NB_LINES; i++) begin
            if (line_req_i[i]) sel_id = `FC_IRQ_ID_W'(i);
        end
    end

    assign any_req    = |line_req_i;
    assign ack_accept = (state_q == ARB_WAIT_ACK) & core_ack_i.valid;

    //**************************************************
    // Request / acknowledge FSM
    //**************************************************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ARB_IDLE;
            irq_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        state_q     <= ARB_WAIT_ACK;
                        irq_valid_q <= 1'b1;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (ack_accept) begin
                        state_q     <= ARB_IDLE;
                        irq_valid_q <= 1'b0;
                    end
                end
                default: begin
                    state_q     <= ARB_IDLE;
                    irq_valid_q <= 1'b0;
                end
            endcase
        end
    end

    // Id is captured when a request is issued
    always_ff @(posedge clk_i) begin
        if (state_q == ARB_IDLE && any_req) irq_id_q <= sel_id;
    end

    assign core_irq_o  = '{valid: irq_valid_q, id: irq_id_q};
    assign ack_bcast_o = '{valid: ack_accept, id: core_ack_i.id};

    // Core side protocol
    a_ack_in_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_ack_i.valid |-> state_q == ARB_WAIT_ACK);
    a_ack_id_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_accept |-> core_ack_i.id == irq_id_q);
    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == ARB_WAIT_ACK && !core_ack_i.valid) |=> $stable(core_irq_o));

endmodule

// ==== fc_irq_subsystem.sv ====
// Event and interrupt subsystem top
`timescale 1ns/10ps
`include "fc_irq_macros.svh"

module fc_irq_subsystem import fc_irq_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`FC_NB_LINES-1:0] events_i,
    input  logic                    event_fifo_valid_i,
    input  logic [`FC_EVT_ID_W-1:0] event_fifo_data_i,
    output logic                    event_fifo_fulln_o,
    input  logic [`FC_NB_LINES-1:0] irq_mask_i,
    output irq_req_t                core_irq_o,
    input  irq_ack_t                core_ack_i,
    output soc_evt_t                soc_evt_o
);

    logic [`FC_NB_LINES-1:0] set_vec;
    logic [`FC_NB_LINES-1:0] line_req;
    irq_ack_t                ack_bcast;

    //**************************************************
    // Event ingress
    //**************************************************
    fc_event_ingress u_ingress (
        .clk_i              ( clk_i              ),
        .arst_n_i           ( arst_n_i           ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .ack_i              ( ack_bcast          ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .set_vec_o          ( set_vec            ),
        .soc_evt_o          ( soc_evt_o          )
    );

    // One pending flag per line
    for (genvar gi = 0; gi < `FC_NB_LINES; gi++) begin : gen_lines
        fc_irq_line #(
            .LINE_ID ( gi )
        ) u_line (
            .clk_i    ( clk_i          ),
            .arst_n_i ( arst_n_i       ),
            .set_i    ( set_vec[gi]    ),
            .mask_i   ( irq_mask_i[gi] ),
            .ack_i    ( ack_bcast      ),
            .req_o    ( line_req[gi]   )
        );
    end

    fc_irq_arbiter u_arbiter (
        .clk_i       ( clk_i      ),
        .arst_n_i    ( arst_n_i   ),
        .line_req_i  ( line_req   ),
        .core_ack_i  ( core_ack_i ),
        .core_irq_o  ( core_irq_o ),
        .ack_bcast_o ( ack_bcast  )
    );

endmodule

// ==== fc_irq_tb.sv ====
// Interrupt subsystem testbench
`timescale 1ns/10ps
`include "fc_irq_macros.svh"

module fc_irq_tb import fc_irq_pkg::*; ();

    localparam int MAX_CYCLES = 6000;
    localparam int SOC_LINE   = `FC_SOC_EVT_LINE;
    localparam int NB_TESTS   = 6;

    logic                    clk_i;
    logic                    arst_n_i;
    logic [`FC_NB_LINES-1:0] events_i;
    logic                    event_fifo_valid_i;
    logic [`FC_EVT_ID_W-1:0] event_fifo_data_i;
    logic                    event_fifo_fulln_o;
    logic [`FC_NB_LINES-1:0] irq_mask_i;
    irq_req_t                core_irq_o;
    irq_ack_t                core_ack_i;
    soc_evt_t                soc_evt_o;

    // Reference model state
    logic [`FC_NB_LINES-1:0] m_pend;
    logic [`FC_NB_LINES-1:0] snap_req;
    logic [`FC_EVT_ID_W-1:0] m_fifo[$];
    logic                    exp_soc_valid;
    logic [`FC_EVT_ID_W-1:0] exp_soc_id;

    logic [31:0]             lcg_state;
    logic                    ack_en;
    logic                    prev_valid;
    int                      presented[$];
    logic [`FC_EVT_ID_W-1:0] soc_seen[$];
    int                      cycle_cnt = 0;
    int                      err_cnt = 0;
    int                      test_err = 0;
    int                      tests_failed = 0;

    fc_irq_subsystem u_fc_irq_subsystem (
        .clk_i              ( clk_i              ),
        .arst_n_i           ( arst_n_i           ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .irq_mask_i         ( irq_mask_i         ),
        .core_irq_o         ( core_irq_o         ),
        .core_ack_i         ( core_ack_i         ),
        .soc_evt_o          ( soc_evt_o          )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Index of the top set bit, -1 when none
    function automatic int highest_line(input logic [`FC_NB_LINES-1:0] vec);
        int idx;
        idx = -1;
        for (int i = 0; i < `FC_NB_LINES; i++) begin
            if (vec[i]) idx = i;
        end
        return idx;
    endfunction

    task automatic report_err(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
        test_err++;
    endtask

    task automatic end_test(input string name);
        if (test_err == 0) begin
            $display("[%0t] %s : ok", $time, name);
        end else begin
            $display("[%0t] %s : %0d error(s)", $time, name, test_err);
            tests_failed++;
        end
        test_err = 0;
    endtask

    // Wait until every unmasked line is served, then check the request stays low
    task automatic wait_drain();
        do begin
            @(negedge clk_i);
        end while ((m_pend & irq_mask_i) != '0 || core_irq_o.valid || core_ack_i.valid);
        repeat (3) begin
            @(negedge clk_i);
            assert (!core_irq_o.valid) else report_err("request raised after drain");
        end
    endtask

    //**************************************************
    // Reference model, same update rules as the lines
    //**************************************************
    always @(posedge clk_i or negedge arst_n_i) begin : ref_model
        logic [`FC_NB_LINES-1:0] set_v;
        logic [`FC_NB_LINES-1:0] clr_v;
        logic                    pop;
        logic                    can_push;
        if (!arst_n_i) begin
            m_pend        = '0;
            snap_req      = '0;
            exp_soc_valid = 1'b0;
            m_fifo.delete();
        end else begin
            snap_req = m_pend & irq_mask_i;
            can_push = m_fifo.size() < `FC_EVT_FIFO_DEPTH;
            pop = core_ack_i.valid && int'(core_ack_i.id) == SOC_LINE && m_fifo.size() > 0;
            exp_soc_valid = pop;
            if (pop) exp_soc_id = m_fifo.pop_front();
            set_v = events_i;
            if (m_fifo.size() > 0) set_v[SOC_LINE] = 1'b1;
            clr_v = '0;
            if (core_ack_i.valid) clr_v[core_ack_i.id] = 1'b1;
            // Set wins over clear
            m_pend = set_v | (m_pend & ~clr_v);
            if (event_fifo_valid_i && can_push) m_fifo.push_back(event_fifo_data_i);
        end
    end

    // Output checks on the falling edge, where DUT outputs are stable
    always @(negedge clk_i) begin : out_check
        int hi;
        if (arst_n_i) begin
            assert (event_fifo_fulln_o == (m_fifo.size() < `FC_EVT_FIFO_DEPTH))
                else report_err("event_fifo_fulln_o differs from model");
            assert (soc_evt_o.valid == exp_soc_valid) else report_err("soc_evt_o.valid wrong");
            if (soc_evt_o.valid) begin
                assert (soc_evt_o.id == exp_soc_id)
                    else report_err($sformatf("soc id %0h, expected %0h", soc_evt_o.id, exp_soc_id));
                soc_seen.push_back(soc_evt_o.id);
            end
            if (core_irq_o.valid && !prev_valid) begin
                hi = highest_line(snap_req);
                assert (snap_req[core_irq_o.id])
                    else report_err($sformatf("id %0d not pending and unmasked", core_irq_o.id));
                assert (int'(core_irq_o.id) == hi)
                    else report_err($sformatf("id %0d, highest is %0d", core_irq_o.id, hi));
                presented.push_back(int'(core_irq_o.id));
            end
            prev_valid = core_irq_o.valid;
        end else begin
            prev_valid = 1'b0;
        end
    end

    // Core side: acknowledge each request after 0 to 3 cycles
    initial begin : core_responder
        int                      dly;
        logic [`FC_IRQ_ID_W-1:0] id;
        core_ack_i = '0;
        forever begin
            @(negedge clk_i);
            if (core_ack_i.valid) begin
                core_ack_i = '0;
            end else if (ack_en && arst_n_i && core_irq_o.valid) begin
                id  = core_irq_o.id;
                dly = int'(lcg_next() % 32'd4);
                repeat (dly) @(negedge clk_i);
                core_ack_i = '{valid: 1'b1, id: id};
            end
        end
    end

    //**************************************************
    // Test sequence
    //**************************************************
    initial begin : main
        logic [31:0]             r;
        logic [`FC_EVT_ID_W-1:0] pushed[$];
        int                      n;
        lcg_state          = 32'hfa33c346;
        ack_en             = 1'b1;
        arst_n_i           = 1'b0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        irq_mask_i         = '1;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        @(negedge clk_i);
        assert (!core_irq_o.valid) else report_err("core_irq_o.valid high after reset");
        assert (!soc_evt_o.valid) else report_err("soc_evt_o.valid high after reset");
        assert (event_fifo_fulln_o) else report_err("event_fifo_fulln_o low after reset");
        end_test("reset_values");

        // Request follows a pulse by exactly 2 cycles
        events_i = 32'd1 << 19;
        @(negedge clk_i);
        events_i = '0;
        assert (!core_irq_o.valid) else report_err("request one cycle early");
        @(negedge clk_i);
        assert (core_irq_o.valid && core_irq_o.id == 5'd19)
            else report_err("no request for line 19 after 2 cycles");
        wait_drain();
        end_test("single_line");

        presented.delete();
        events_i = 32'hc002_0209;
        @(negedge clk_i);
        events_i = '0;
        wait_drain();
        assert (presented.size() == 6 && presented[0] == 31)
            else report_err($sformatf("%0d requests, expected 6", presented.size()));
        for (int i = 1; i < presented.size(); i++) begin
            assert (presented[i] < presented[i-1]) else report_err("order not descending");
        end
        end_test("descending_order");

        irq_mask_i = ~(32'd1 << 12);
        events_i   = 32'd1 << 12;
        @(negedge clk_i);
        events_i = '0;
        repeat (6) begin
            @(negedge clk_i);
            assert (!core_irq_o.valid) else report_err("masked line 12 raised a request");
        end
        irq_mask_i = '1;
        @(negedge clk_i);
        assert (core_irq_o.valid && core_irq_o.id == 5'd12)
            else report_err("line 12 not requested after unmask");
        wait_drain();
        end_test("mask_gating");

        // Fill the FIFO with the core stalled, fifth push must be dropped
        ack_en = 1'b0;
        presented.delete();
        soc_seen.delete();
        for (int i = 0; i < `FC_EVT_FIFO_DEPTH; i++) begin
            r = lcg_next();
            event_fifo_valid_i = 1'b1;
            event_fifo_data_i  = r[7:0];
            pushed.push_back(r[7:0]);
            @(negedge clk_i);
        end
        assert (!event_fifo_fulln_o) else report_err("fulln high with a full FIFO");
        event_fifo_data_i = 8'hee;
        @(negedge clk_i);
        event_fifo_valid_i = 1'b0;
        ack_en = 1'b1;
        wait_drain();
        assert (soc_seen.size() == 4) else report_err("wrong number of SoC events");
        for (int i = 0; i < soc_seen.size() && i < 4; i++) begin
            assert (soc_seen[i] == pushed[i]) else report_err("SoC event out of push order");
        end
        n = 0;
        foreach (presented[i]) begin
            if (presented[i] == SOC_LINE) n++;
        end
        assert (n == 4 && presented.size() == 4)
            else report_err($sformatf("line 26 requested %0d times", n));
        end_test("soc_event_fifo");

        // Sparse random events, pushes and mask flips
        soc_seen.delete();
        n = 0;
        for (int c = 0; c < 1500; c++) begin
            r = lcg_next();
            events_i = (r[2:0] == 3'd0) ? (lcg_next() & lcg_next() & lcg_next()) : '0;
            event_fifo_valid_i = (r[7:4] == 4'd0);
            event_fifo_data_i  = r[15:8];
            if (r[21:16] == 6'd0) irq_mask_i = irq_mask_i ^ (32'd1 << r[26:22]);
            // Pushes that find room in the FIFO
            if (event_fifo_valid_i && m_fifo.size() < `FC_EVT_FIFO_DEPTH) n++;
            @(negedge clk_i);
        end
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        irq_mask_i         = '1;
        wait_drain();
        assert (soc_seen.size() == n)
            else report_err($sformatf("%0d SoC events reported, %0d pushes accepted",
                                      soc_seen.size(), n));
        end_test("random_run");

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 NB_TESTS, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== fc_irq.f ====
+incdir+.
fc_irq_pkg.sv
fc_event_ingress.sv
fc_irq_line.sv
fc_irq_arbiter.sv
fc_irq_subsystem.sv
fc_irq_tb.sv

// ==== Makefile ====
SRCS = fc_irq.f fc_irq_macros.svh fc_irq_pkg.sv fc_event_ingress.sv fc_irq_line.sv \
       fc_irq_arbiter.sv fc_irq_subsystem.sv fc_irq_tb.sv

.PHONY: all run lint clean

all: run

obj_dir/Vfc_irq_tb: $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		-f fc_irq.f --top-module fc_irq_tb -o Vfc_irq_tb

run: obj_dir/Vfc_irq_tb
	./obj_dir/Vfc_irq_tb 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "Simulation reported failures"; exit 1; \
	elif ! grep -q "All tests passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		-f fc_irq.f --top-module fc_irq_subsystem

clean:
	rm -rf obj_dir sim.log
